// File: include/node_lookup_cfg.svh
`ifndef NODE_LOOKUP_CFG_SVH
`define NODE_LOOKUP_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Table geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define NL_MAX_NODES 100           // One record per table word.
`define NL_ADDR_W 7                // Enough to index all of the table.
`define NL_FIELD_W 16              // Every record field has this width.
`define NL_RECORD_W 272            // Seventeen fields packed side by side.
`define NL_CHILD_SLOTS 6           // A node has at most six children.
`define NL_EMPTY_ID 800            // Marker for id, parent and cost of an empty record.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Field positions inside a record
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// The x coordinate sits in the top field and y follows it.
`define NL_OFS_X 256               // Low bit of the x coordinate.
`define NL_OFS_ID 224              // Low bit of the node id.
`define NL_OFS_PARENT 208          // Low bit of the parent id.
`define NL_OFS_COST 192            // Low bit of the current cost.
`define NL_OFS_CHILD_BASE 176      // Low bit of the first child id.
// Each child takes an id field followed by a distance field, so the
// next child id is two fields further down.

`endif

// File: hdl/graph_record_pkg.sv
`include "node_lookup_cfg.svh"

package graph_record_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Widths that carry a meaning
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef logic [`NL_FIELD_W-1:0] node_id_t;       // A node number as stored in a record.
	typedef logic [`NL_ADDR_W-1:0] table_addr_t;     // An index into the node table.
	typedef logic [`NL_RECORD_W-1:0] node_record_t;  // One whole table entry.

	// All six child records, slot zero in the lowest bits.
	typedef logic [`NL_CHILD_SLOTS*`NL_RECORD_W-1:0] child_set_t;

	// One bit per child slot, at most one bit set at a time.
	typedef logic [`NL_CHILD_SLOTS-1:0] slot_sel_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Empty record
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Coordinates, child ids and distances are all zero.
	// Id, parent and cost carry the empty marker so a planner
	// never mistakes the slot for a real node.
	localparam node_record_t empty_record =
		(node_record_t'(`NL_EMPTY_ID) << `NL_OFS_ID) |
		(node_record_t'(`NL_EMPTY_ID) << `NL_OFS_PARENT) |
		(node_record_t'(`NL_EMPTY_ID) << `NL_OFS_COST);

endpackage

// File: hdl/lookup_ctrl_pkg.sv
package lookup_ctrl_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Lookup control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [2:0] {
		IDLE        = 3'd0,    // Waiting for find_node.
		NODE_SCAN   = 3'd1,    // Issuing addresses to find the target node.
		NODE_DRAIN  = 3'd2,    // Last node read has landed, decide on the child pass.
		CHILD_SCAN  = 3'd3,    // Issuing addresses to collect the children.
		CHILD_DRAIN = 3'd4,    // Let the final child read settle.
		FINISH      = 3'd5     // One cycle of done.
	} lookup_state_t;

	// Tag carried next to each read so that stale data is recognised.
	typedef enum logic {
		PHASE_NODE  = 1'b0,    // Read belongs to the node pass.
		PHASE_CHILD = 1'b1     // Read belongs to the child pass.
	} read_phase_t;

endpackage

// File: hdl/node_mem.sv
`include "node_lookup_cfg.svh"

module node_mem (
	input  logic                          clk,
	input  logic                          write_enable,
	input  graph_record_pkg::table_addr_t write_address,
	input  graph_record_pkg::node_record_t write_data,
	input  graph_record_pkg::table_addr_t read_address,
	input  logic                          read_valid,
	input  lookup_ctrl_pkg::read_phase_t  read_phase,
	output graph_record_pkg::node_record_t read_data,
	output logic                          data_valid,
	output lookup_ctrl_pkg::read_phase_t  data_phase
);
	import graph_record_pkg::*;
	import lookup_ctrl_pkg::*;

	node_record_t table_q [`NL_MAX_NODES];    // The node table itself.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write port
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (write_enable) begin
			table_q[write_address] <= write_data;    // The host loads one record per cycle.
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Registered read port
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		read_data <= table_q[read_address];    // Data shows up one cycle after its address.
		data_valid <= read_valid;               // The valid bit travels with the data.
		data_phase <= read_phase;               // So does the pass it was issued for.
	end

	// A new address may be presented every cycle, so several reads
	// can be in flight and each keeps its own tag.

endmodule

// File: hdl/lookup_sequencer.sv
`include "node_lookup_cfg.svh"

module lookup_sequencer (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          find_node,
	input  graph_record_pkg::node_id_t    node_id,
	input  logic                          node_captured,
	input  logic                          children_full,
	output graph_record_pkg::table_addr_t read_address,
	output logic                          read_valid,
	output lookup_ctrl_pkg::read_phase_t  read_phase,
	output graph_record_pkg::node_id_t    target_id,
	output logic                          clear,
	output logic                          done,
	output logic                          found
);
	import graph_record_pkg::*;
	import lookup_ctrl_pkg::*;

	localparam table_addr_t last_addr = table_addr_t'(`NL_MAX_NODES - 1);

	lookup_state_t state;    // Where the lookup stands.
	logic sweep_done;        // Set once the last table address has been issued.
	logic accept;            // A request is taken this cycle.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address stream decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign accept = (state == IDLE) && find_node;    // Requests outside IDLE are dropped.
	assign clear = accept;                           // Results are emptied as the lookup begins.

	// Issue stops as soon as the bank reports the node or a full set of children.
	assign read_valid = ((state == NODE_SCAN) && !node_captured && !sweep_done) ||
		((state == CHILD_SCAN) && !children_full && !sweep_done);
	assign read_phase = (state == CHILD_SCAN) ? PHASE_CHILD : PHASE_NODE;
	assign done = (state == FINISH);                 // Exactly one cycle long.

	always_ff @(posedge clk) begin
		if (accept) begin
			target_id <= node_id;    // Held for the whole lookup.
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Lookup FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			read_address <= '0;
			sweep_done <= 1'b0;
			found <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (find_node) begin
						state <= NODE_SCAN;         // Address zero goes out next cycle.
						read_address <= '0;
						sweep_done <= 1'b0;
					end
				end
				NODE_SCAN: begin
					// The cycle after the last issue lets that read come back.
					if (node_captured || sweep_done) begin
						state <= NODE_DRAIN;
					end
				end
				NODE_DRAIN: begin
					found <= node_captured;         // Every node read has landed by now.
					if (node_captured) begin
						state <= CHILD_SCAN;        // Second sweep starts from the top.
						read_address <= '0;
						sweep_done <= 1'b0;
					end else begin
						state <= FINISH;            // Missing node, no child pass.
					end
				end
				CHILD_SCAN: begin
					if (children_full || sweep_done) begin
						state <= CHILD_DRAIN;
					end
				end
				CHILD_DRAIN: state <= FINISH;
				FINISH: state <= IDLE;
				default: state <= IDLE;
			endcase
			// One address per cycle while a sweep is issuing.
			if (read_valid) begin
				if (read_address == last_addr) begin
					sweep_done <= 1'b1;             // Table exhausted.
				end else begin
					read_address <= read_address + 1'b1;
				end
			end
		end
	end

endmodule

// File: hdl/record_matcher.sv
`include "node_lookup_cfg.svh"

module record_matcher (
	input  graph_record_pkg::node_record_t read_data,
	input  logic                           data_valid,
	input  lookup_ctrl_pkg::read_phase_t   data_phase,
	input  graph_record_pkg::node_id_t     target_id,
	input  graph_record_pkg::node_record_t node,
	input  logic                           node_captured,
	output logic                           node_hit,
	output graph_record_pkg::slot_sel_t    child_select
);
	import graph_record_pkg::*;
	import lookup_ctrl_pkg::*;

	node_id_t data_id;        // Id of the record coming back from the table.
	slot_sel_t slot_match;    // Slots whose child id equals data_id.
	logic child_ok;           // A child-pass record worth comparing.

	assign data_id = read_data[`NL_OFS_ID +: `NL_FIELD_W];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Node pass
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Only the first matching record is taken. Reads that were already
	// in flight when the node was captured fall through here.
	assign node_hit = data_valid && (data_phase == PHASE_NODE) &&
		!node_captured && (data_id == target_id);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Child pass
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Id zero marks an unused child entry and never matches.
	assign child_ok = data_valid && (data_phase == PHASE_CHILD) && (data_id != '0);

	genvar k;
	generate
		for (k = 0; k < `NL_CHILD_SLOTS; k++) begin : g_cmp
			// Child ids step down two fields per slot.
			assign slot_match[k] =
				(data_id == node[(`NL_OFS_CHILD_BASE - 2*`NL_FIELD_W*k) +: `NL_FIELD_W]);
		end
	endgenerate

	// Slot zero has the highest priority, then slot one and so on.
	always_comb begin
		child_select = '0;
		for (int i = `NL_CHILD_SLOTS - 1; i >= 0; i--) begin
			if (child_ok && slot_match[i]) begin
				child_select = slot_sel_t'(1) << i;    // Lower slots override higher ones.
			end
		end
	end

	// The node record is stable during the whole child pass, since the
	// bank captured it before the second sweep began.

endmodule

// File: hdl/child_slot_bank.sv
`include "node_lookup_cfg.svh"

module child_slot_bank (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           clear,
	input  logic                           node_hit,
	input  graph_record_pkg::slot_sel_t    child_select,
	input  graph_record_pkg::node_record_t read_data,
	output graph_record_pkg::node_record_t node,
	output graph_record_pkg::child_set_t   children,
	output logic                           node_captured,
	output logic                           children_full
);
	import graph_record_pkg::*;

	node_record_t slot_q [`NL_CHILD_SLOTS];    // One record per child slot.
	logic [2:0] child_count;                   // Children captured so far.
	logic child_take;                          // A child record is stored this cycle.

	assign children_full = (child_count == 3'(`NL_CHILD_SLOTS));
	assign child_take = (|child_select) && !children_full;    // Nothing lands past six.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Capture flags and count
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (reset) begin
			node_captured <= 1'b0;
			child_count <= '0;
		end else if (clear) begin
			node_captured <= 1'b0;                  // A new lookup starts empty.
			child_count <= '0;
		end else begin
			if (node_hit) begin
				node_captured <= 1'b1;
			end
			if (child_take) begin
				child_count <= child_count + 1'b1;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Record storage
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (clear) begin
			node <= empty_record;                   // Stays empty when the node is missing.
			for (int i = 0; i < `NL_CHILD_SLOTS; i++) begin
				slot_q[i] <= empty_record;          // Unmatched slots keep this.
			end
		end else begin
			if (node_hit) begin
				node <= read_data;                  // Captured the cycle the data returns.
			end
			for (int i = 0; i < `NL_CHILD_SLOTS; i++) begin
				if (child_take && child_select[i]) begin
					slot_q[i] <= read_data;
				end
			end
		end
	end

	genvar k;
	generate
		for (k = 0; k < `NL_CHILD_SLOTS; k++) begin : g_pack
			assign children[k*`NL_RECORD_W +: `NL_RECORD_W] = slot_q[k];    // Slot zero lowest.
		end
	endgenerate

endmodule

// File: hdl/node_lookup_top.sv
module node_lookup_top (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           write_enable,
	input  graph_record_pkg::table_addr_t  write_address,
	input  graph_record_pkg::node_record_t write_data,
	input  logic                           find_node,
	input  graph_record_pkg::node_id_t     node_id,
	output logic                           done,
	output logic                           found,
	output graph_record_pkg::node_record_t node,
	output graph_record_pkg::child_set_t   children
);
	import graph_record_pkg::*;
	import lookup_ctrl_pkg::*;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Internal wiring
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	table_addr_t read_address;    // Address stream from the sequencer.
	logic read_valid;
	read_phase_t read_phase;
	node_record_t read_data;      // Record returning from the table.
	logic data_valid;
	read_phase_t data_phase;
	node_id_t target_id;          // Id latched at the request.
	logic node_hit;
	slot_sel_t child_select;
	logic node_captured;
	logic children_full;
	logic clear;

	node_mem u_node_mem (
		.clk(clk), .write_enable(write_enable), .write_address(write_address),
		.write_data(write_data), .read_address(read_address), .read_valid(read_valid),
		.read_phase(read_phase), .read_data(read_data), .data_valid(data_valid),
		.data_phase(data_phase)
	);

	lookup_sequencer u_lookup_sequencer (
		.clk(clk), .reset(reset), .find_node(find_node), .node_id(node_id),
		.node_captured(node_captured), .children_full(children_full),
		.read_address(read_address), .read_valid(read_valid), .read_phase(read_phase),
		.target_id(target_id), .clear(clear), .done(done), .found(found)
	);

	record_matcher u_record_matcher (
		.read_data(read_data), .data_valid(data_valid), .data_phase(data_phase),
		.target_id(target_id), .node(node), .node_captured(node_captured),
		.node_hit(node_hit), .child_select(child_select)
	);

	child_slot_bank u_child_slot_bank (
		.clk(clk), .reset(reset), .clear(clear), .node_hit(node_hit),
		.child_select(child_select), .read_data(read_data), .node(node),
		.children(children), .node_captured(node_captured), .children_full(children_full)
	);

endmodule

// File: sim/node_lookup_checker.sv
`include "node_lookup_cfg.svh"

module node_lookup_checker (
	input logic                           clk,
	input logic                           reset,
	input logic                           write_enable,
	input graph_record_pkg::table_addr_t  write_address,
	input graph_record_pkg::node_record_t write_data,
	input logic                           find_node,
	input graph_record_pkg::node_id_t     node_id,
	input logic                           done,
	input logic                           found,
	input graph_record_pkg::node_record_t node,
	input graph_record_pkg::child_set_t   children
);
	import graph_record_pkg::*;

	node_record_t shadow [`NL_MAX_NODES];       // Copy of the table as the host wrote it.
	node_id_t target_q;                         // Id of the accepted request.
	logic busy;                                 // A lookup is in progress.
	logic seen_request;                         // At least one request was accepted.
	logic exp_found;                            // The target exists in the shadow table.
	node_record_t exp_node;                     // Expected node output.
	node_record_t exp_slot [`NL_CHILD_SLOTS];   // Expected child slots.
	int fail_count = 0;                         // Failed assertions so far.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Shadow table and request tracking
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (write_enable) begin
			shadow[write_address] <= write_data;    // Mirrors the DUT write port.
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			seen_request <= 1'b0;
		end else if (find_node && !busy) begin
			busy <= 1'b1;                           // Requests while busy are ignored.
			seen_request <= 1'b1;
			target_q <= node_id;
		end else if (done) begin
			busy <= 1'b0;
		end
	end

	// Search by id. Misses give the empty record.
	function automatic logic table_has(input node_id_t id, output node_record_t rec);
		logic hit;
		hit = 1'b0;
		rec = empty_record;
		for (int a = 0; a < `NL_MAX_NODES; a++) begin
			if (!hit && (shadow[a][`NL_OFS_ID +: `NL_FIELD_W] == id)) begin
				hit = 1'b1;
				rec = shadow[a];
			end
		end
		return hit;
	endfunction

	always_comb begin
		node_id_t cid;
		node_record_t rec;
		logic hit;
		exp_found = table_has(target_q, exp_node);    // Empty record when the node is absent.
		for (int k = 0; k < `NL_CHILD_SLOTS; k++) begin
			cid = exp_node[(`NL_OFS_CHILD_BASE - 2*`NL_FIELD_W*k) +: `NL_FIELD_W];
			hit = table_has(cid, rec);
			exp_slot[k] = ((cid != '0) && hit) ? rec : empty_record;    // Id zero is no child.
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Assertions
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Outputs settle after the rising edge, so they are sampled on the falling one.
	a_done_single: assert property (@(negedge clk) disable iff (reset) done |=> !done)
		else begin fail_count++; $error("done stayed high for more than one cycle"); end
	a_done_requested: assert property (@(negedge clk) disable iff (reset) done |-> busy)
		else begin fail_count++; $error("done pulsed without an accepted request"); end
	a_quiet_start: assert property (@(negedge clk) disable iff (reset)
		!seen_request |-> (!done && !found))
		else begin fail_count++; $error("done or found high before the first request"); end
	a_found: assert property (@(negedge clk) disable iff (reset) done |-> (found == exp_found))
		else begin
			fail_count++;
			$error("CHECK FAILED found: got %h expected %h", found, exp_found);
		end
	a_node: assert property (@(negedge clk) disable iff (reset) done |-> (node == exp_node))
		else begin
			fail_count++;
			$error("CHECK FAILED node: got %h expected %h", node, exp_node);
		end

	genvar k;
	generate
		for (k = 0; k < `NL_CHILD_SLOTS; k++) begin : g_slot
			a_slot: assert property (@(negedge clk) disable iff (reset)
				done |-> (children[k*`NL_RECORD_W +: `NL_RECORD_W] == exp_slot[k]))
				else begin
					fail_count++;
					$error("CHECK FAILED children slot %0d: got %h expected %h", k,
						children[k*`NL_RECORD_W +: `NL_RECORD_W], exp_slot[k]);
				end
		end
	endgenerate

endmodule

// File: sim/node_lookup_tb.sv
`include "node_lookup_cfg.svh"

module node_lookup_tb;
	import graph_record_pkg::*;

	localparam int done_timeout = 600;    // Cycles allowed for one lookup.
	localparam int query_count = 25;

	logic clk;
	logic reset;
	logic write_enable;
	table_addr_t write_address;
	node_record_t write_data;
	logic find_node;
	node_id_t node_id;
	logic done;
	logic found;
	node_record_t node;
	child_set_t children;

	node_id_t ids [`NL_MAX_NODES];    // Node id stored at each table address.
	int timeouts;                     // Lookups that never signalled done.

	node_lookup_top uut (
		.clk(clk), .reset(reset), .write_enable(write_enable),
		.write_address(write_address), .write_data(write_data), .find_node(find_node),
		.node_id(node_id), .done(done), .found(found), .node(node), .children(children)
	);

	bind node_lookup_top node_lookup_checker u_checker (
		.clk(clk), .reset(reset), .write_enable(write_enable),
		.write_address(write_address), .write_data(write_data), .find_node(find_node),
		.node_id(node_id), .done(done), .found(found), .node(node), .children(children)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;    // Period of 100.
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Table contents
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic node_record_t make_record(input int addr);
		node_record_t rec;
		node_id_t cid;
		int start;
		int kind;
		rec = '0;
		start = int'($urandom % `NL_MAX_NODES);
		rec[`NL_OFS_X +: `NL_FIELD_W] = node_id_t'($urandom);
		rec[(`NL_OFS_X - `NL_FIELD_W) +: `NL_FIELD_W] = node_id_t'($urandom);    // The y field.
		rec[`NL_OFS_ID +: `NL_FIELD_W] = ids[addr];
		rec[`NL_OFS_PARENT +: `NL_FIELD_W] = ids[$urandom % `NL_MAX_NODES];
		rec[`NL_OFS_COST +: `NL_FIELD_W] = node_id_t'($urandom % 5000);
		for (int k = 0; k < `NL_CHILD_SLOTS; k++) begin
			kind = (addr % 10 == 0) ? 0 : int'($urandom % 3);    // Every tenth node fills all six.
			case (kind)
				0: cid = ids[(start + 7*k) % `NL_MAX_NODES];      // Distinct existing ids.
				1: cid = '0;
				default: cid = node_id_t'(101 + 6*($urandom % 100) + k);    // Not in the table.
			endcase
			rec[(`NL_OFS_CHILD_BASE - 2*`NL_FIELD_W*k) +: `NL_FIELD_W] = cid;
			rec[(`NL_OFS_CHILD_BASE - 2*`NL_FIELD_W*k - `NL_FIELD_W) +: `NL_FIELD_W] =
				node_id_t'($urandom % 1000);
		end
		return rec;
	endfunction

	task automatic load_table();
		int j;
		node_id_t tmp;
		for (int a = 0; a < `NL_MAX_NODES; a++) begin
			ids[a] = node_id_t'(a + 1);
		end
		for (int a = `NL_MAX_NODES - 1; a > 0; a--) begin
			j = int'($urandom % (a + 1));    // Shuffle the ids over the addresses.
			tmp = ids[a];
			ids[a] = ids[j];
			ids[j] = tmp;
		end
		for (int a = 0; a < `NL_MAX_NODES; a++) begin
			@(negedge clk);
			write_enable = 1'b1;
			write_address = table_addr_t'(a);
			write_data = make_record(a);
		end
		@(negedge clk);
		write_enable = 1'b0;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Lookups
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic run_query(input node_id_t id, input logic stray);
		int cycles;
		@(negedge clk);
		find_node = 1'b1;
		node_id = id;
		@(negedge clk);
		find_node = 1'b0;
		cycles = 0;
		while (!done && cycles < done_timeout) begin
			find_node = stray && (cycles == 3);    // A request mid-lookup must be ignored.
			if (find_node) begin
				node_id = node_id_t'(id + 1);      // A different target would show a restart.
			end
			@(negedge clk);
			cycles++;
		end
		find_node = 1'b0;
		if (!done) begin
			timeouts++;
			$display("Timeout: lookup of node id %0d gave no done within %0d cycles",
				id, done_timeout);
		end else begin
			@(negedge clk);    // Step out of the done cycle.
		end
	endtask

	task automatic run_queries();
		node_id_t query;
		for (int q = 0; q < query_count; q++) begin
			case (q)
				0: query = ids[0];
				1: query = ids[`NL_MAX_NODES - 1];
				2: query = '0;                     // Absent ids follow.
				3: query = 16'd150;
				4: query = node_id_t'(`NL_EMPTY_ID);
				5: query = ids[50];
				default: query = ids[$urandom % `NL_MAX_NODES];
			endcase
			run_query(query, q == 7);
		end
	endtask

	initial begin
		int fail_total;
		void'($urandom(72071));
		reset = 1'b1;
		write_enable = 1'b0;
		write_address = '0;
		write_data = '0;
		find_node = 1'b0;
		node_id = '0;
		timeouts = 0;
		repeat (10) @(negedge clk);
		reset = 1'b0;
		load_table();
		run_queries();
		repeat (3) @(negedge clk);    // Let the last checks complete.
		fail_total = timeouts + uut.u_checker.fail_count;
		$display("Errors: %0d assertion failures, %0d timeouts",
			uut.u_checker.fail_count, timeouts);
		if (fail_total == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: sources.f
+incdir+include
hdl/graph_record_pkg.sv
hdl/lookup_ctrl_pkg.sv
hdl/node_mem.sv
hdl/lookup_sequencer.sv
hdl/record_matcher.sv
hdl/child_slot_bank.sv
hdl/node_lookup_top.sv
sim/node_lookup_checker.sv
sim/node_lookup_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the node lookup testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f sources.f --top-module node_lookup_tb -o node_lookup_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/node_lookup_sim +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^Finished with no errors$"; then
	exit 0
fi
exit 1
